// File: Makefile
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_apb_regs.sv
rtl/uart_top.sv
tests/uart_sva.sv
tests/uart_tb.sv

// File: rtl/uart_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs import uart_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // APB slave
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [APB_ADDR_W-1:0] paddr,
    input  wire logic [APB_DATA_W-1:0] pwdata,
    output logic      [APB_DATA_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    // TX FIFO
    input  wire logic                  tx_full,
    input  wire logic                  tx_empty,
    output logic                       tx_push,
    output logic      [7:0]            tx_wdata,
    // RX FIFO
    input  wire logic                  rx_full,
    input  wire logic                  rx_empty,
    input  wire rx_entry_t             rx_head,
    output logic                       rx_pop,
    // Receiver
    input  wire logic                  rx_valid,
    input  wire rx_entry_t             rx_entry,
    output logic                       rx_push,
    output rx_entry_t                  rx_wdata
);

    logic                  access;                   // APB access phase
    logic                  unmapped;
    logic                  wr_data;
    logic                  rd_data;
    logic                  rd_status;
    logic                  wr_clear;
    logic                  overrun;                  // Sticky RX drop flag
    logic [APB_DATA_W-1:0] status_word;

    assign access    = psel && penable;              // Zero wait states
    assign unmapped  = (paddr != ADDR_DATA) && (paddr != ADDR_STATUS) &&
                       (paddr != ADDR_CLEAR);
    assign wr_data   = access && pwrite && (paddr == ADDR_DATA);
    assign rd_data   = access && !pwrite && (paddr == ADDR_DATA);
    assign rd_status = access && !pwrite && (paddr == ADDR_STATUS);
    assign wr_clear  = access && pwrite && (paddr == ADDR_CLEAR) && pwdata[0];

    assign tx_push  = wr_data && !tx_full;           // Byte dropped when full
    assign tx_wdata = pwdata[7:0];
    assign rx_pop   = rd_data && !rx_empty;          // Takes effect at cycle end
    assign rx_push  = rx_valid && !rx_full;
    assign rx_wdata = rx_entry;

    assign pready  = 1'b1;
    assign pslverr = (access && unmapped) || (wr_data && tx_full) || (rd_data && rx_empty);

    always_ff @(posedge clk) begin
        if (reset) begin
            overrun <= 1'b0;
        end else if (rx_valid && rx_full) begin
            overrun <= 1'b1;                         // Set beats a same-cycle clear
        end else if (wr_clear) begin
            overrun <= 1'b0;
        end
    end

    always_comb begin
        status_word                 = '0;
        status_word[STAT_TX_FULL]   = tx_full;
        status_word[STAT_TX_EMPTY]  = tx_empty;
        status_word[STAT_RX_EMPTY]  = rx_empty;
        status_word[STAT_OVERRUN]   = overrun;
        status_word[STAT_FRAME_ERR] = !rx_empty && rx_head.frame_err; // Head entry only
    end

    always_comb begin
        prdata = '0;                                 // Also for empty data reads
        if (rx_pop) begin
            prdata[7:0]                = rx_head.data;
            prdata[DATA_FRAME_ERR_BIT] = rx_head.frame_err;
        end else if (rd_status) begin
            prdata = status_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter type payload_t = logic [7:0],          // Entry format
    parameter int  DEPTH     = 4                     // Number of entries
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     push,                      // Caller masks with !full
    input  wire payload_t wdata,
    input  wire logic     pop,                       // Caller masks with !empty
    output payload_t      rdata,                     // Show-ahead head entry
    output logic          full,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);        // Must hold DEPTH itself

    payload_t         mem [DEPTH];                   // Storage
    logic [PTR_W-1:0] wr_ptr;                        // Next free slot
    logic [PTR_W-1:0] rd_ptr;                        // Oldest entry
    logic [CNT_W-1:0] count;                         // Occupancy

    // Wrap works for any depth, not just powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;                    // Write at the tail
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;           // Both at once leaves count as is
            end
        end
    end

    assign rdata = mem[rd_ptr];                      // Valid whenever !empty
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // APB bus geometry
    parameter int APB_ADDR_W = 4;                    // Byte address bits
    parameter int APB_DATA_W = 32;                   // Word width

    // Register map
    parameter logic [APB_ADDR_W-1:0] ADDR_DATA   = 4'h0; // Wr pushes TX, rd pops RX
    parameter logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4; // Read only flags
    parameter logic [APB_ADDR_W-1:0] ADDR_CLEAR  = 4'h8; // Bit 0 clears overrun

    // Status word bit positions
    parameter int STAT_TX_FULL   = 0;
    parameter int STAT_TX_EMPTY  = 1;
    parameter int STAT_RX_EMPTY  = 2;
    parameter int STAT_OVERRUN   = 3;                // Sticky until cleared
    parameter int STAT_FRAME_ERR = 4;                // Head of RX queue only

    // Framing error position in a data read word
    parameter int DATA_FRAME_ERR_BIT = 8;

    // One received character as queued in the RX FIFO
    typedef struct packed {
        logic       frame_err;                       // Stop bit sampled low
        logic [7:0] data;                            // LSB was first on the line
    } rx_entry_t;

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8                   // Clocks per serial bit
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic rx,                            // Asynchronous serial line
    output logic      rx_valid,                      // One cycle per frame
    output rx_entry_t rx_entry
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             rx_meta;                       // First sync stage
    logic             rx_sync;                       // Safe to use
    logic             busy;                          // Inside a frame
    logic             wait_high;                     // Line stuck low after bad stop
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;                       // 0 start, 1..8 data, 9 stop
    logic [7:0]       shift_reg;                     // Data bits, LSB arrives first
    logic             sample;                        // Mid-bit strobe

    assign sample = busy && (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            wait_high <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (wait_high) begin
                    wait_high <= !rx_sync;           // Rearm once line is back high
                end else if (!rx_sync) begin
                    busy     <= 1'b1;                // Falling edge of start bit
                    baud_cnt <= CNT_W'(CLKS_PER_BIT / 2); // Half bit offset
                    bit_idx  <= '0;
                end
            end else if (sample) begin
                baud_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                if ((bit_idx == 4'd0) && rx_sync) begin
                    busy <= 1'b0;                    // Start bit was only a glitch
                end else if (bit_idx == 4'd9) begin
                    busy      <= 1'b0;
                    wait_high <= !rx_sync;           // Only after a framing error
                    rx_valid  <= 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && (bit_idx != 4'd0) && (bit_idx != 4'd9)) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};  // Data bit
        end
        if (sample && (bit_idx == 4'd9)) begin
            rx_entry.data      <= shift_reg;
            rx_entry.frame_err <= !rx_sync;          // Stop bit must be high
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; #(
    parameter int CLK_FREQ   = 1000000,              // Hz
    parameter int BAUD_RATE  = 125000,               // Bits per second
    parameter int FIFO_DEPTH = 4                     // Entries per queue
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [APB_ADDR_W-1:0] paddr,
    input  wire logic [APB_DATA_W-1:0] pwdata,
    output logic      [APB_DATA_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire logic                  rx,
    output logic                       tx
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE; // Rounds down

    logic       tx_full;
    logic       tx_empty;
    logic       tx_push;
    logic       tx_pop;
    logic [7:0] tx_wdata;
    logic [7:0] tx_head;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_valid;
    rx_entry_t  rx_entry;                            // From receiver
    rx_entry_t  rx_wdata;                            // Into RX FIFO
    rx_entry_t  rx_head;                             // Oldest unread entry

    uart_apb_regs u_regs (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tx_full(tx_full), .tx_empty(tx_empty), .tx_push(tx_push), .tx_wdata(tx_wdata),
        .rx_full(rx_full), .rx_empty(rx_empty), .rx_head(rx_head), .rx_pop(rx_pop),
        .rx_valid(rx_valid), .rx_entry(rx_entry), .rx_push(rx_push), .rx_wdata(rx_wdata)
    );

    uart_fifo #(.payload_t(logic [7:0]), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .reset(reset),
        .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
        .rdata(tx_head), .full(tx_full), .empty(tx_empty)
    );

    uart_fifo #(.payload_t(rx_entry_t), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk(clk), .reset(reset),
        .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
        .rdata(rx_head), .full(rx_full), .empty(rx_empty)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk(clk), .reset(reset),
        .fifo_empty(tx_empty), .fifo_data(tx_head), .fifo_pop(tx_pop), .tx(tx)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk(clk), .reset(reset),
        .rx(rx), .rx_valid(rx_valid), .rx_entry(rx_entry)
    );

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8                   // Clocks per serial bit
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       fifo_empty,
    input  wire logic [7:0] fifo_data,               // Head of TX FIFO
    output logic            fifo_pop,
    output logic            tx                       // Serial line, idles high
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             busy;                          // Frame on the line
    logic [CNT_W-1:0] baud_cnt;                      // Cycle within current bit
    logic [3:0]       bit_idx;                       // 0 start, 1..8 data, 9 stop
    logic [9:0]       shift_reg;                     // Bit 0 is driven on tx
    logic             bit_end;                       // Last cycle of a bit
    logic             frame_end;                     // Last cycle of stop bit

    assign bit_end   = busy && (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign frame_end = bit_end && (bit_idx == 4'd9);

    // Pop during the stop bit's last cycle too, so frames run back to back
    assign fifo_pop  = (!busy || frame_end) && !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= '1;                         // Line high out of reset
        end else if (fifo_pop) begin
            busy      <= 1'b1;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= {1'b1, fifo_data, 1'b0};    // Stop, data, start
        end else if (bit_end) begin
            baud_cnt  <= '0;
            bit_idx   <= frame_end ? 4'd0 : bit_idx + 1'b1;
            busy      <= !frame_end;
            shift_reg <= {1'b1, shift_reg[9:1]};     // Ones fill in behind
        end else if (busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign tx = shift_reg[0];                        // Straight from a flop

endmodule

`default_nettype wire

// File: tests/uart_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sva (
    input wire logic clk,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr,
    input wire logic tx
);

    // Zero wait state slave
    a_pready_high: assert property (@(posedge clk) pready)
        else $error("pready dropped low");

    // Line idles high from the first reset edge on
    a_tx_high_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> tx)
        else $error("tx low while reset is active");

    a_pslverr_in_access: assert property (@(posedge clk) pslverr |-> psel && penable)
        else $error("pslverr raised outside an access cycle");

endmodule

bind uart_top uart_sva u_sva (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .tx(tx)
);

`default_nettype wire

// File: tests/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

    localparam int CLK_FREQ     = 1000000;
    localparam int BAUD_RATE    = 125000;
    localparam int FIFO_DEPTH   = 4;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;  // Eight here
    localparam int LOOP_BYTES   = 20;
    localparam int STATUS_POLLS = 200;                   // Per status wait
    localparam int LOOP_POLLS   = 5000;                  // Whole loopback test

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  tx;
    logic                  rx_line;
    logic                  drv_line;                     // Serial driver output
    logic                  loopback;                     // 1 routes tx back to rx

    logic [15:0] lfsr_state;
    logic [8:0]  rx_model [$];                           // {frame_err, data}
    int          check_count;
    int          error_count;
    int          check_base;
    int          error_base;

    assign rx_line = loopback ? tx : drv_line;

    uart_top #(
        .CLK_FREQ(CLK_FREQ),
        .BAUD_RATE(BAUD_RATE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) UUT (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .rx(rx_line), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                           // 4 ns period
    end

    // Galois form with taps x^16 x^14 x^13 x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);          // One step per bit
            b[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [31:0] expected_status(input logic tx_full_f,
                                                    input logic tx_empty_f,
                                                    input logic rx_empty_f,
                                                    input logic overrun_f,
                                                    input logic frame_err_f);
        logic [31:0] w;
        w = '0;
        w[STAT_TX_FULL]   = tx_full_f;
        w[STAT_TX_EMPTY]  = tx_empty_f;
        w[STAT_RX_EMPTY]  = rx_empty_f;
        w[STAT_OVERRUN]   = overrun_f;
        w[STAT_FRAME_ERR] = frame_err_f;
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic begin_test();
        check_base = check_count;
        error_base = error_count;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, check_count - check_base,
                 error_count - error_base);
    endtask

    // Setup cycle, then one access cycle; outputs sampled mid access
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check("pready", 32'(pready), 32'h1);             // Zero wait states
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;                                   // Valid in the access cycle
        err  = pslverr;
        check("pready", 32'(pready), 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Start, eight data bits LSB first, stop, then one idle bit
    task automatic serial_send(input logic [7:0] data, input logic bad_stop);
        logic [10:0] frame;
        frame = {1'b1, ~bad_stop, data, 1'b0};
        for (int b = 0; b < 11; b++) begin
            @(posedge clk);
            drv_line <= frame[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic wait_status(input int pos, input logic val);
        logic [31:0] stat;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(ADDR_STATUS, stat, err);
        while ((stat[pos] !== val) && (polls < STATUS_POLLS)) begin
            apb_read(ADDR_STATUS, stat, err);
            polls++;
        end
        if (stat[pos] !== val) begin
            $display("Timeout waiting for status bit %0d to read %0d", pos, val);
            error_count++;
        end
    endtask

    // Pops one entry and compares with the head of the model
    task automatic read_expect();
        logic [31:0] data;
        logic        err;
        logic [8:0]  entry;
        logic [31:0] exp_word;
        apb_read(ADDR_DATA, data, err);
        if (rx_model.size() == 0) begin
            $display("Data read while the model expected no byte");
            error_count++;
        end else begin
            entry = rx_model.pop_front();
            exp_word = '0;
            exp_word[7:0] = entry[7:0];
            exp_word[DATA_FRAME_ERR_BIT] = entry[8];
            check("prdata", data, exp_word);
        end
        check("pslverr", 32'(err), 32'h0);
    endtask

    task automatic drain_expect(input int n);
        for (int k = 0; k < n; k++) begin
            wait_status(STAT_RX_EMPTY, 1'b0);
            read_expect();
        end
    endtask

    task automatic test_reset();
        logic [31:0] stat;
        logic        err;
        begin_test();
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
        check("pslverr", 32'(err), 32'h0);
        check("tx", 32'(tx), 32'h1);                     // Line idle
        finish_test("reset state");
    endtask

    task automatic test_loopback();
        logic [31:0] stat;
        logic        err;
        logic [7:0]  b;
        int          sent;
        int          got;
        int          polls;
        begin_test();
        sent  = 0;
        got   = 0;
        polls = 0;
        @(posedge clk);
        loopback <= 1'b1;
        while ((got < LOOP_BYTES) && (polls < LOOP_POLLS)) begin
            polls++;
            apb_read(ADDR_STATUS, stat, err);
            if (!stat[STAT_RX_EMPTY]) begin
                read_expect();
                got++;
            end else if ((sent < LOOP_BYTES) && !stat[STAT_TX_FULL] &&
                         ((sent - got) < FIFO_DEPTH)) begin   // Keeps RX from overflowing
                rand_byte(b);
                apb_write(ADDR_DATA, 32'(b), err);
                check("pslverr", 32'(err), 32'h0);
                rx_model.push_back({1'b0, b});
                sent++;
            end
        end
        if (got < LOOP_BYTES) begin
            $display("Timeout in loopback, only %0d of %0d bytes came back", got, LOOP_BYTES);
            error_count++;
        end
        finish_test("loopback");
    endtask

    task automatic test_errors();
        logic [31:0] data;
        logic        err;
        logic [7:0]  b;
        begin_test();
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin  // One in the shifter, rest queued
            rand_byte(b);
            apb_write(ADDR_DATA, 32'(b), err);
            check("pslverr", 32'(err), 32'h0);
            rx_model.push_back({1'b0, b});
        end
        wait_status(STAT_TX_FULL, 1'b1);
        rand_byte(b);
        apb_write(ADDR_DATA, 32'(b), err);               // Must be dropped
        check("pslverr", 32'(err), 32'h1);
        drain_expect(FIFO_DEPTH + 1);
        repeat (12 * CLKS_PER_BIT) @(posedge clk);       // Room for a stray frame
        apb_read(ADDR_DATA, data, err);
        check("pslverr", 32'(err), 32'h1);               // RX empty
        check("prdata", data, 32'h0);
        apb_read(4'hC, data, err);
        check("pslverr", 32'(err), 32'h1);               // Unmapped read
        apb_write(4'hC, 32'h1, err);
        check("pslverr", 32'(err), 32'h1);               // Unmapped write
        finish_test("slave errors");
    endtask

    task automatic test_overrun();
        logic [31:0] stat;
        logic        err;
        logic [7:0]  b;
        begin_test();
        @(posedge clk);
        loopback <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            rand_byte(b);
            if (i < FIFO_DEPTH) begin
                rx_model.push_back({1'b0, b});           // Last two get dropped
            end
            serial_send(b, 1'b0);
        end
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
        drain_expect(FIFO_DEPTH);
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b1, 1'b1, 1'b0));
        apb_write(ADDR_CLEAR, 32'h1, err);
        check("pslverr", 32'(err), 32'h0);
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
        finish_test("overrun");
    endtask

    task automatic test_framing();
        logic [31:0] stat;
        logic        err;
        logic [7:0]  b;
        begin_test();
        rand_byte(b);
        rx_model.push_back({1'b1, b});
        serial_send(b, 1'b1);                            // Stop bit low
        rand_byte(b);
        rx_model.push_back({1'b0, b});
        serial_send(b, 1'b0);
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
        drain_expect(1);
        apb_read(ADDR_STATUS, stat, err);
        check("status", stat, expected_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
        drain_expect(1);
        finish_test("framing error");
    endtask

    initial begin
        lfsr_state  = 16'd51206;
        check_count = 0;
        error_count = 0;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        drv_line = 1'b1;                                 // Idle line
        loopback = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_loopback();
        test_errors();
        test_overrun();
        test_framing();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hard stop if a test never finishes
    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
